//--- hw/alarm_unit.sv
// alarm latches on an exact h:m:s match while enabled and holds until the enable drops
`timescale 1ns/10ps

module alarm_unit #(
	parameter int TONE_DIV = 25_000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_alarm_en,
	input  logic [clock_pkg::FIELD_W-1:0] i_time_hour,
	input  logic [clock_pkg::FIELD_W-1:0] i_time_min,
	input  logic [clock_pkg::FIELD_W-1:0] i_time_sec,
	input  logic [clock_pkg::FIELD_W-1:0] i_alarm_hour,
	input  logic [clock_pkg::FIELD_W-1:0] i_alarm_min,
	input  logic [clock_pkg::FIELD_W-1:0] i_alarm_sec,
	output logic                          o_buzz
);

	logic tone;
	logic match;
	logic alarm_latch;

	// square wave with a half period of TONE_DIV cycles
	tick_gen #(
		.DIV		(TONE_DIV)
	) u_tone (
		.clk		(clk),
		.rst_n		(rst_n),
		.o_tick		(),
		.o_level	(tone)
	);

	assign match = (i_time_hour == i_alarm_hour) &&
	               (i_time_min  == i_alarm_min)  &&
	               (i_time_sec  == i_alarm_sec);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alarm_latch <= 1'b0;
		else if (!i_alarm_en)
			alarm_latch <= 1'b0;	// switching off silences it
		else if (match)
			alarm_latch <= 1'b1;
	end

	assign o_buzz = tone & alarm_latch;

endmodule

//--- hw/button_ctrl.sv
// buttons 0..3 are mode, position, increment and alarm enable, active low; a press needs two btn_ticks
`timescale 1ns/10ps

module button_ctrl #(
	parameter int BTN_DIV = 500_000
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [3:0]       i_btn_n,
	output clock_pkg::mode_t o_mode,
	output clock_pkg::pos_t  o_pos,
	output logic             o_alarm_en,
	output logic             o_inc_time,
	output logic             o_inc_alarm,
	output logic             o_run
);

	import clock_pkg::*;

	logic       btn_tick;
	logic [3:0] btn_meta;
	logic [3:0] btn_sync;
	logic [3:0] btn_prev;	// level seen on the previous btn_tick
	logic [3:0] press;

	tick_gen #(
		.DIV		(BTN_DIV)
	) u_btn_tick (
		.clk		(clk),
		.rst_n		(rst_n),
		.o_tick		(btn_tick),
		.o_level	()
	);

	// --------------------------------------------------
	// sync and press detect
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_meta <= '1;	// released
			btn_sync <= '1;
			btn_prev <= '1;
		end else begin
			btn_meta <= i_btn_n;
			btn_sync <= btn_meta;
			if (btn_tick)
				btn_prev <= btn_sync;
		end
	end

	assign press = {4{btn_tick}} & btn_prev & ~btn_sync;	// high then low

	// --------------------------------------------------
	// mode, position, alarm enable
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			o_pos      <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (press[0]) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (press[1]) begin
				case (o_pos)
					POS_SEC: o_pos <= POS_MIN;
					POS_MIN: o_pos <= POS_HOUR;
					default: o_pos <= POS_SEC;
				endcase
			end
			if (press[3])
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// increment goes to whichever counter is being edited
	assign o_inc_time  = press[2] && (o_mode == MODE_SETUP);
	assign o_inc_alarm = press[2] && (o_mode == MODE_ALARM);
	assign o_run       = (o_mode != MODE_SETUP);	// time stands still while set

	a_enc_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(o_mode inside {MODE_CLOCK, MODE_SETUP, MODE_ALARM}) &&
		(o_pos inside {POS_SEC, POS_MIN, POS_HOUR}));

endmodule

//--- hw/clock_pkg.sv
// shared encodings for the hh:mm:ss clock; segment vectors are {a..g}, active high, six digits fixed
package clock_pkg;

	// --------------------------------------------------
	// modes and edit positions
	// --------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	// --------------------------------------------------
	// field limits and widths
	// --------------------------------------------------
	localparam int FIELD_W    = 6;	// holds 0..59
	localparam int DIGIT_W    = 4;	// one bcd digit
	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;

	localparam logic [FIELD_W-1:0] SEC_MAX  = FIELD_W'(59);
	localparam logic [FIELD_W-1:0] MIN_MAX  = FIELD_W'(59);
	localparam logic [FIELD_W-1:0] HOUR_MAX = FIELD_W'(23);

	typedef logic [SEG_W-1:0] seg_t;	// bit 6 is segment a, bit 0 is g

	localparam seg_t SEG_BLANK = '0;

	// digits above 9 stay dark
	function automatic seg_t seg_of_digit(input logic [DIGIT_W-1:0] digit);
		case (digit)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return SEG_BLANK;
		endcase
	endfunction

endpackage

//--- hw/clock_top.sv
// single clock domain; defaults assume a 50 MHz clk, all dividers can be overridden for simulation
`timescale 1ns/10ps

module clock_top #(
	parameter int SEC_DIV   = 50_000_000,
	parameter int SCAN_DIV  = 5_000,
	parameter int BTN_DIV   = 500_000,
	parameter int BLINK_DIV = 25_000_000,
	parameter int TONE_DIV  = 25_000
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [3:0]                       i_btn_n,
	output clock_pkg::seg_t                  o_seg,
	output logic                             o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                             o_buzz
);

	import clock_pkg::*;

	logic                     sec_tick;
	logic                     blink;
	mode_t                    mode;
	pos_t                     pos;
	logic                     alarm_en;
	logic                     inc_time;
	logic                     inc_alarm;
	logic                     run;
	logic [FIELD_W-1:0]       time_hour, time_min, time_sec;
	logic [FIELD_W-1:0]       alarm_hour, alarm_min, alarm_sec;
	seg_t [NUM_DIGITS-1:0]    digits;

	// --------------------------------------------------
	// timing strobes
	// --------------------------------------------------
	tick_gen #(.DIV(SEC_DIV)) u_sec_tick (
		.clk(clk), .rst_n(rst_n), .o_tick(sec_tick), .o_level()
	);

	tick_gen #(.DIV(BLINK_DIV)) u_blink (
		.clk(clk), .rst_n(rst_n), .o_tick(), .o_level(blink)
	);

	button_ctrl #(.BTN_DIV(BTN_DIV)) u_button_ctrl (
		.clk(clk), .rst_n(rst_n), .i_btn_n(i_btn_n),
		.o_mode(mode), .o_pos(pos), .o_alarm_en(alarm_en),
		.o_inc_time(inc_time), .o_inc_alarm(inc_alarm), .o_run(run)
	);

	// --------------------------------------------------
	// time and alarm registers
	// --------------------------------------------------
	hms_counter u_time (
		.clk(clk), .rst_n(rst_n), .i_tick(sec_tick), .i_run(run),
		.i_step(inc_time), .i_pos(pos),
		.o_hour(time_hour), .o_min(time_min), .o_sec(time_sec)
	);

	hms_counter u_alarm (
		.clk(clk), .rst_n(rst_n), .i_tick(sec_tick), .i_run(1'b0),	// never runs
		.i_step(inc_alarm), .i_pos(pos),
		.o_hour(alarm_hour), .o_min(alarm_min), .o_sec(alarm_sec)
	);

	alarm_unit #(.TONE_DIV(TONE_DIV)) u_alarm_unit (
		.clk(clk), .rst_n(rst_n), .i_alarm_en(alarm_en),
		.i_time_hour(time_hour), .i_time_min(time_min), .i_time_sec(time_sec),
		.i_alarm_hour(alarm_hour), .i_alarm_min(alarm_min), .i_alarm_sec(alarm_sec),
		.o_buzz(o_buzz)
	);

	// --------------------------------------------------
	// display path
	// --------------------------------------------------
	digit_render u_digit_render (
		.i_mode(mode), .i_pos(pos), .i_blink(blink),
		.i_time_hour(time_hour), .i_time_min(time_min), .i_time_sec(time_sec),
		.i_alarm_hour(alarm_hour), .i_alarm_min(alarm_min), .i_alarm_sec(alarm_sec),
		.o_digits(digits)
	);

	scan_driver #(.SCAN_DIV(SCAN_DIV)) u_scan_driver (
		.clk(clk), .rst_n(rst_n), .i_digits(digits), .i_mode(mode),
		.o_seg(o_seg), .o_seg_dp(o_seg_dp), .o_seg_enb(o_seg_enb)
	);

endmodule

//--- hw/digit_render.sv
// digit 0 is seconds ones, digit 5 hours tens; edited field blanks while i_blink is low
`timescale 1ns/10ps

module digit_render (
	input  clock_pkg::mode_t                            i_mode,
	input  clock_pkg::pos_t                             i_pos,
	input  logic                                        i_blink,
	input  logic [clock_pkg::FIELD_W-1:0]               i_time_hour,
	input  logic [clock_pkg::FIELD_W-1:0]               i_time_min,
	input  logic [clock_pkg::FIELD_W-1:0]               i_time_sec,
	input  logic [clock_pkg::FIELD_W-1:0]               i_alarm_hour,
	input  logic [clock_pkg::FIELD_W-1:0]               i_alarm_min,
	input  logic [clock_pkg::FIELD_W-1:0]               i_alarm_sec,
	output clock_pkg::seg_t [clock_pkg::NUM_DIGITS-1:0] o_digits
);

	import clock_pkg::*;

	localparam int NUM_FIELDS = NUM_DIGITS / 2;

	logic [FIELD_W-1:0] field [NUM_FIELDS];	// sec, min, hour
	logic               edit;

	// --------------------------------------------------
	// source select
	// --------------------------------------------------
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			field[0] = i_alarm_sec;
			field[1] = i_alarm_min;
			field[2] = i_alarm_hour;
		end else begin
			field[0] = i_time_sec;
			field[1] = i_time_min;
			field[2] = i_time_hour;
		end
	end

	assign edit = (i_mode != MODE_CLOCK) && !i_blink;	// blank phase of the blink

	// --------------------------------------------------
	// split and decode
	// --------------------------------------------------
	always_comb begin
		for (int f = 0; f < NUM_FIELDS; f++) begin
			if (edit && (i_pos == pos_t'(f))) begin
				o_digits[2*f]   = SEG_BLANK;
				o_digits[2*f+1] = SEG_BLANK;
			end else begin
				o_digits[2*f]   = seg_of_digit(DIGIT_W'(field[f] % 10));	// ones
				o_digits[2*f+1] = seg_of_digit(DIGIT_W'(field[f] / 10));	// tens
			end
		end
	end

endmodule

//--- hw/hms_counter.sv
// 24-hour h:m:s register set; i_tick with i_run counts with carry, i_step bumps one field only
`timescale 1ns/10ps

module hms_counter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_tick,
	input  logic                          i_run,
	input  logic                          i_step,
	input  clock_pkg::pos_t               i_pos,
	output logic [clock_pkg::FIELD_W-1:0] o_hour,
	output logic [clock_pkg::FIELD_W-1:0] o_min,
	output logic [clock_pkg::FIELD_W-1:0] o_sec
);

	import clock_pkg::*;

	logic count;

	// next value with wrap to zero past the limit
	function automatic logic [FIELD_W-1:0] next_val(
		input logic [FIELD_W-1:0] val,
		input logic [FIELD_W-1:0] max
	);
		return (val >= max) ? '0 : val + 1'b1;
	endfunction

	assign count = i_tick & i_run;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_hour <= '0;
			o_min  <= '0;
			o_sec  <= '0;
		end else if (count) begin
			o_sec <= next_val(o_sec, SEC_MAX);
			if (o_sec == SEC_MAX) begin	// carry into minutes
				o_min <= next_val(o_min, MIN_MAX);
				if (o_min == MIN_MAX)
					o_hour <= next_val(o_hour, HOUR_MAX);
			end
		end else if (i_step) begin
			// no carry when editing
			case (i_pos)
				POS_SEC:  o_sec  <= next_val(o_sec, SEC_MAX);
				POS_MIN:  o_min  <= next_val(o_min, MIN_MAX);
				POS_HOUR: o_hour <= next_val(o_hour, HOUR_MAX);
				default:  ;
			endcase
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	a_field_range: assert property (@(posedge clk) disable iff (!rst_n)
		(o_sec <= SEC_MAX) && (o_min <= MIN_MAX) && (o_hour <= HOUR_MAX));

endmodule

//--- hw/scan_driver.sv
// one digit lit at a time, enables active low; scan restarts at digit 0 after reset
`timescale 1ns/10ps

module scan_driver #(
	parameter int SCAN_DIV = 5_000
) (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  clock_pkg::seg_t [clock_pkg::NUM_DIGITS-1:0] i_digits,
	input  clock_pkg::mode_t                            i_mode,
	output clock_pkg::seg_t                             o_seg,
	output logic                                        o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0]            o_seg_enb
);

	import clock_pkg::*;

	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic                  scan_tick;
	logic [IDX_W-1:0]      idx;
	logic [NUM_DIGITS-1:0] dp_mask;

	tick_gen #(
		.DIV		(SCAN_DIV)
	) u_scan_tick (
		.clk		(clk),
		.rst_n		(rst_n),
		.o_tick		(scan_tick),
		.o_level	()
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx <= '0;
		else if (scan_tick)
			idx <= (idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
	end

	// decimal points tell the mode
	always_comb begin
		case (i_mode)
			MODE_CLOCK: dp_mask = 6'b010101;	// field separators
			MODE_SETUP: dp_mask = 6'b000001;
			MODE_ALARM: dp_mask = 6'b000010;
			default:    dp_mask = '0;
		endcase
	end

	assign o_seg_enb = ~(NUM_DIGITS'(1) << idx);
	assign o_seg     = i_digits[idx];
	assign o_seg_dp  = dp_mask[idx];

	a_enb_one_cold: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

//--- hw/tick_gen.sv
// DIV must be at least 2; o_tick is one cycle wide every DIV cycles, o_level starts low
`timescale 1ns/10ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick,
	output logic o_level
);

	localparam int CNT_W = $clog2(DIV);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= '0;
			o_tick  <= 1'b0;
			o_level <= 1'b0;
		end else if (cnt == CNT_W'(DIV - 1)) begin
			cnt     <= '0;
			o_tick  <= 1'b1;
			o_level <= ~o_level;	// half period is DIV cycles
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

	// strobe never stretches over two cycles
	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
		o_tick |=> !o_tick);

endmodule

//--- sources.f
hw/clock_pkg.sv
hw/tick_gen.sv
hw/button_ctrl.sv
hw/hms_counter.sv
hw/alarm_unit.sv
hw/digit_render.sv
hw/scan_driver.sv
hw/clock_top.sv
tb/tb_clock_top.sv

//--- tb/tb_clock_top.sv
// directed tests with small dividers; time reads start 40 clocks after a second boundary
`timescale 1ns/10ps

module tb_clock_top;

	localparam int SEC_DIV    = 400;
	localparam int SCAN_DIV   = 4;
	localparam int BTN_DIV    = 8;
	localparam int BLINK_DIV  = 64;
	localparam int TONE_DIV   = 3;
	localparam int PHASE      = 40;	// clear of the seconds update
	localparam int HOUR_STEPS = 25;	// wraps the hours once
	localparam int ALARM_MIN  = 7;
	localparam int DAY        = 86400;

	logic       clk;
	logic       rst_n;
	logic [3:0] btn_n;
	logic [6:0] seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       buzz;

	int         cyc;	// clocks since reset release
	int         errors;
	int         test_errors;
	int         tests;
	int         alarm_h, alarm_m, alarm_s;	// alarm value as set by the tests
	logic [6:0] disp_seg [6];
	logic [5:0] disp_dp;

	clock_top #(
		.SEC_DIV	(SEC_DIV),
		.SCAN_DIV	(SCAN_DIV),
		.BTN_DIV	(BTN_DIV),
		.BLINK_DIV	(BLINK_DIV),
		.TONE_DIV	(TONE_DIV)
	) u_dut (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn_n	(btn_n),
		.o_seg		(seg),
		.o_seg_dp	(seg_dp),
		.o_seg_enb	(seg_enb),
		.o_buzz		(buzz)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [6:0] seg_pattern(input int d);
		case (d)	// segments a..g with a as the msb
			0:       return 7'b1111110;
			1:       return 7'b0110000;
			2:       return 7'b1101101;
			3:       return 7'b1111001;
			4:       return 7'b0110011;
			5:       return 7'b1011011;
			6:       return 7'b1011111;
			7:       return 7'b1110000;
			8:       return 7'b1111111;
			default: return 7'b1110011;
		endcase
	endfunction

	// -1 for a dark digit, -2 for a pattern that is no digit
	function automatic int digit_of_seg(input logic [6:0] pattern);
		if (pattern == 7'b0)
			return -1;
		for (int d = 0; d < 10; d++)
			if (seg_pattern(d) == pattern)
				return d;
		return -2;
	endfunction

	function automatic int tod(input int h, input int m, input int s);
		return h * 3600 + m * 60 + s;
	endfunction

	task automatic abort_on_timeout(input string what);
		$display("timeout at %0t: no %s", $time, what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic check_true(input bit cond, input string msg);
		assert (cond) else begin
			$display("CHECK FAILED at %0t: %s", $time, msg);
			test_errors++;
		end
	endtask

	task automatic check_time(input int h, input int m, input int s, input int exp,
			input string what);
		check_true(tod(h, m, s) == exp,
			$sformatf("%s: read %02d:%02d:%02d, expected %02d:%02d:%02d", what,
				h, m, s, exp / 3600, (exp / 60) % 60, exp % 60));
	endtask

	task automatic press_button(input int idx);
		@(posedge clk);
		btn_n[idx] <= 1'b0;
		repeat (4 * BTN_DIV) @(posedge clk);
		btn_n[idx] <= 1'b1;
		repeat (4 * BTN_DIV) @(posedge clk);
	endtask

	task automatic wait_for_cycle(input int target);
		int guard;
		guard = 0;
		while (cyc < target) begin
			@(negedge clk);
			guard++;
			if (guard > 100 * SEC_DIV)
				abort_on_timeout("end of a cycle wait");
		end
	endtask

	function automatic int next_second();
		return cyc / SEC_DIV + 1;
	endfunction

	// one pass over the six digits sampled at the falling edge
	task automatic read_display();
		int guard;
		for (int d = 0; d < 6; d++) begin
			guard = 0;
			@(negedge clk);
			while (seg_enb != ~(6'b1 << d)) begin
				check_true($onehot(~seg_enb), "digit enables not one-cold");
				@(negedge clk);
				guard++;
				if (guard > 8 * SCAN_DIV * 6)
					abort_on_timeout($sformatf("enable of digit %0d", d));
			end
			disp_seg[d] = seg;
			disp_dp[d]  = seg_dp;
		end
	endtask

	task automatic read_time(output int h, output int m, output int s);
		int dig [6];
		int tries;
		bit blank;
		tries = 0;
		do begin
			read_display();
			blank = 1'b0;
			for (int d = 0; d < 6; d++) begin
				dig[d] = digit_of_seg(disp_seg[d]);
				check_true(dig[d] != -2, $sformatf("digit %0d pattern %b", d, disp_seg[d]));
				if (dig[d] == -1)
					blank = 1'b1;	// blink phase so read again
				else if (dig[d] < 0)
					dig[d] = 0;
			end
			tries++;
			if (blank && tries > 8)
				abort_on_timeout("lit display after blinking");
		end while (blank);
		h = dig[5] * 10 + dig[4];
		m = dig[3] * 10 + dig[2];
		s = dig[1] * 10 + dig[0];
	endtask

	task automatic count_buzz_high(input int until_cyc, output int highs);
		int guard;
		highs = 0;
		guard = 0;
		while (cyc < until_cyc) begin
			@(negedge clk);
			if (buzz)
				highs++;
			guard++;
			if (guard > 100 * SEC_DIV)
				abort_on_timeout("end of a buzzer watch");
		end
	endtask

	task automatic wait_buzz(input logic level, input int limit, input string what);
		int guard;
		guard = 0;
		while (buzz !== level) begin
			@(negedge clk);
			guard++;
			if (guard > limit)
				abort_on_timeout(what);
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %-16s %s (%0d errors)", tests, name,
			(test_errors == 0) ? "pass" : "FAIL", test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_reset();
		int h, m, s, highs;
		read_time(h, m, s);
		check_time(h, m, s, 0, "after reset");
		check_true(disp_dp == 6'b010101, $sformatf("clock mode dp %b", disp_dp));
		count_buzz_high(cyc + 200, highs);
		check_true(highs == 0, "buzzer active after reset");
	endtask

	task automatic test_count(input int k);
		int h, m, s;
		wait_for_cycle(k * SEC_DIV + PHASE);
		read_time(h, m, s);
		check_time(h, m, s, k % DAY, $sformatf("after %0d seconds", k));
	endtask

	task automatic test_setup();
		int h0, m0, s0, h, m, s, exp;
		bit seen_blank, seen_lit;
		wait_for_cycle(next_second() * SEC_DIV + PHASE);
		read_time(h0, m0, s0);
		press_button(0);	// to setup before the next second
		press_button(1);
		press_button(1);	// hour field
		for (int i = 0; i < HOUR_STEPS; i++)
			press_button(2);
		exp = tod((h0 + HOUR_STEPS) % 24, m0, s0);
		read_time(h, m, s);
		check_time(h, m, s, exp, "hours stepped in setup");
		check_true(disp_dp == 6'b000001, $sformatf("setup mode dp %b", disp_dp));
		repeat (2 * SEC_DIV) @(posedge clk);
		read_time(h, m, s);
		check_time(h, m, s, exp, "time frozen in setup");
		seen_blank = 1'b0;
		seen_lit   = 1'b0;
		for (int i = 0; i < 12; i++) begin
			read_display();
			if (disp_seg[5] == 7'b0 && disp_seg[4] == 7'b0)
				seen_blank = 1'b1;
			else if (disp_seg[5] != 7'b0 && disp_seg[4] != 7'b0)
				seen_lit = 1'b1;
		end
		check_true(seen_blank, "hour digits never blank while edited");
		check_true(seen_lit, "hour digits never lit while edited");
	endtask

	task automatic test_alarm_set();
		int h, m, s, k, t0;
		press_button(0);	// setup to alarm
		read_time(h, m, s);
		check_true(disp_dp == 6'b000010, $sformatf("alarm mode dp %b", disp_dp));
		check_time(h, m, s, 0, "alarm before setting");
		press_button(1);
		press_button(1);	// hour, sec, then min
		for (int i = 0; i < ALARM_MIN; i++)
			press_button(2);
		alarm_h = 0;
		alarm_m = ALARM_MIN;
		alarm_s = 0;
		read_time(h, m, s);
		check_time(h, m, s, tod(alarm_h, alarm_m, alarm_s), "alarm minutes");
		press_button(0);	// back to clock
		k = next_second();
		wait_for_cycle(k * SEC_DIV + PHASE);
		read_time(h, m, s);
		t0 = tod(h, m, s);
		wait_for_cycle((k + 3) * SEC_DIV + PHASE);
		read_time(h, m, s);
		check_time(h, m, s, (t0 + 3) % DAY, "counting after alarm mode");
	endtask

	task automatic test_alarm_fire();
		int h0, m0, s0, k0, lead, target, ph, pm, ps, cost, highs, rise_cyc;
		k0 = next_second();
		wait_for_cycle(k0 * SEC_DIV + PHASE);
		read_time(h0, m0, s0);
		// far enough ahead that all presses are done first
		lead = 2;
		do begin
			lead++;
			target = (tod(h0, m0, s0) + lead) % DAY;
			ph = (target / 3600 - alarm_h + 24) % 24;
			pm = ((target / 60) % 60 - alarm_m + 60) % 60;
			ps = (target % 60 - alarm_s + 60) % 60;
			cost = (ph + pm + ps + 7) * 8 * BTN_DIV;
		end while (lead * SEC_DIV < cost + 2 * SEC_DIV);
		press_button(0);
		press_button(0);	// through setup into alarm
		press_button(1);	// min to hour
		repeat (ph) press_button(2);
		press_button(1);	// hour to sec
		repeat (ps) press_button(2);
		press_button(1);	// sec to min
		repeat (pm) press_button(2);
		press_button(0);	// clock mode
		press_button(3);	// alarm on
		count_buzz_high((k0 + lead - 1) * SEC_DIV + PHASE, highs);
		check_true(highs == 0, "buzzer before the alarm time");
		wait_buzz(1'b1, 2 * SEC_DIV, "buzzer at the alarm time");
		rise_cyc = cyc;
		check_true(rise_cyc >= (k0 + lead) * SEC_DIV,
			$sformatf("buzzer at cycle %0d, alarm second starts at %0d",
				rise_cyc, (k0 + lead) * SEC_DIV));
		wait_buzz(1'b0, 4 * TONE_DIV, "buzzer tone toggling low");
		wait_buzz(1'b1, 4 * TONE_DIV, "buzzer tone toggling high");
		press_button(3);	// alarm off
		count_buzz_high(cyc + 2 * SEC_DIV, highs);
		check_true(highs == 0, "buzzer after the alarm is disabled");
	endtask

	// --------------------------------------------------
	// sequence
	// --------------------------------------------------
	initial begin
		rst_n       = 1'b0;
		btn_n       = 4'hf;	// all released
		errors      = 0;
		test_errors = 0;
		tests       = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		test_reset();
		finish_test("reset");
		test_count(62);
		finish_test("timekeeping");
		test_setup();
		finish_test("setup");
		test_alarm_set();
		finish_test("alarm set");
		test_alarm_fire();
		finish_test("alarm fire");

		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
